// File: verilog/arena_video_pkg.sv
// shared constants and types for the arena video pipeline
// raster is fixed at 800x521 with the pixel clock assumed near 25 MHz
// grid is 10x10 tiles of 64x48 pixels; offsets are 6 bits so a tile must fit in 64
// porch positions are parameters set by the top level
`default_nettype none

package arena_video_pkg;

	//////////////////////////////////////////////////
	// raster timing

	localparam int H_TOTAL = 800; // clocks per line
	localparam int V_TOTAL = 521; // lines per frame
	localparam int H_PULSE = 96;  // hsync low below this count
	localparam int V_PULSE = 2;   // vsync low below this line

	//////////////////////////////////////////////////
	// picture and grid geometry

	localparam int ACTIVE_W = 640;
	localparam int ACTIVE_H = 480;
	localparam int GRID_N   = 10;  // tiles per row and per column
	localparam int TILE_W   = 64;  // ACTIVE_W / GRID_N
	localparam int TILE_H   = 48;  // ACTIVE_H / GRID_N

	typedef logic [3:0] cell_idx_t;                 // tile row or column, 0..9
	typedef logic [5:0] tile_off_t;                 // pixel offset inside a tile
	typedef logic [GRID_N*GRID_N-1:0] grid_map_t;   // bit = row*10 + col

	// row counts tiles down the screen and col across it
	typedef struct packed {
		cell_idx_t row;
		cell_idx_t col;
	} player_pos_t;

	typedef enum logic [1:0] {
		GAME_RUNNING = 2'd0,
		P1_WINS      = 2'd1,
		P2_WINS      = 2'd2,
		GAME_DRAW    = 2'd3
	} game_over_e;

	// tile occupants listed in no particular priority order
	typedef enum logic [2:0] {
		TILE_BACKGROUND = 3'd0,
		TILE_BLOCK      = 3'd1,
		TILE_BOMB1      = 3'd2,
		TILE_BOMB2      = 3'd3,
		TILE_BOMB3      = 3'd4,
		TILE_PLAYER1    = 3'd5,
		TILE_PLAYER2    = 3'd6
	} tile_kind_e;

	// 3-3-2 colour as driven to the dac pins
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb_t;

	//////////////////////////////////////////////////
	// pipeline stage payloads

	// raster position in 23 bits
	typedef struct packed {
		logic      hsync_n;
		logic      vsync_n;
		logic      active;  // inside the 640x480 picture
		cell_idx_t row;
		cell_idx_t col;
		tile_off_t off_x;   // 0..63
		tile_off_t off_y;   // 0..47
	} beam_t;

	// classified pixel in 18 bits
	typedef struct packed {
		logic       hsync_n;
		logic       vsync_n;
		logic       active;
		tile_kind_e kind;
		tile_off_t  off_x;
		tile_off_t  off_y;
	} paint_req_t;

endpackage

`default_nettype wire

// File: verilog/raster_timing.sv
// free running 800x521 raster with active low syncs
// porches must keep the whole 640x480 picture inside the raster
// tile row, column and offsets are counters, so no divider is needed
// beam_o is combinational from registers with zero latency
`timescale 1ns/1ns
`default_nettype none

module raster_timing
	import arena_video_pkg::*;
#(
	parameter int H_BACK = 144, // first active column
	parameter int V_BACK = 31   // first active line
) (
	input  wire   pixel_clk,
	input  wire   rst,
	output beam_t beam_o
);

	logic [9:0] h_cnt;   // 0 .. H_TOTAL-1
	logic [9:0] v_cnt;   // 0 .. V_TOTAL-1
	cell_idx_t  col_q;
	cell_idx_t  row_q;
	tile_off_t  off_x_q;
	tile_off_t  off_y_q;
	logic       line_end;
	logic       h_act;
	logic       v_act;
	logic       active;

	assign line_end = (h_cnt == 10'(H_TOTAL - 1));

	// half-open windows that start at the porch edge
	assign h_act  = (h_cnt >= 10'(H_BACK)) && (h_cnt < 10'(H_BACK + ACTIVE_W));
	assign v_act  = (v_cnt >= 10'(V_BACK)) && (v_cnt < 10'(V_BACK + ACTIVE_H));
	assign active = h_act && v_act;

	//////////////////////////////////////////////////
	// raster counters

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			// vertical steps once per line
			v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	//////////////////////////////////////////////////
	// tile counters stand in for a divide by 64 and by 48

	// horizontal part runs only on active pixels
	// after the last column it has wrapped to 0/0 for the next line
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			off_x_q <= '0;
			col_q   <= '0;
		end else if (active) begin
			if (off_x_q == 6'(TILE_W - 1)) begin
				off_x_q <= '0;                 // next tile
				col_q   <= (col_q == 4'(GRID_N - 1)) ? '0 : col_q + 4'd1;
			end else begin
				off_x_q <= off_x_q + 6'd1;
			end
		end
	end

	// vertical part steps at the end of each active line
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			off_y_q <= '0;
			row_q   <= '0;
		end else if (line_end && v_act) begin
			if (off_y_q == 6'(TILE_H - 1)) begin
				off_y_q <= '0;
				row_q   <= (row_q == 4'(GRID_N - 1)) ? '0 : row_q + 4'd1;
			end else begin
				off_y_q <= off_y_q + 6'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// beam out

	always_comb begin
		beam_o.hsync_n = (h_cnt >= 10'(H_PULSE)); // low during the pulse
		beam_o.vsync_n = (v_cnt >= 10'(V_PULSE));
		beam_o.active  = active;
		beam_o.row     = row_q;
		beam_o.col     = col_q;
		beam_o.off_x   = off_x_q;
		beam_o.off_y   = off_y_q;
	end

	// offsets and grid index stay in range over the whole picture
	a_tile_bounds : assert property (@(posedge pixel_clk) disable iff (rst)
		active |-> (int'(off_x_q) < TILE_W) && (int'(off_y_q) < TILE_H)
			&& (int'(row_q) < GRID_N) && (int'(col_q) < GRID_N));

	// counters come back to the origin by the first pixel of every frame
	a_frame_origin : assert property (@(posedge pixel_clk) disable iff (rst)
		(h_cnt == 10'(H_BACK)) && (v_cnt == 10'(V_BACK))
			|-> (off_x_q == '0) && (off_y_q == '0) && (row_q == '0) && (col_q == '0));

endmodule

`default_nettype wire

// File: verilog/tile_classifier.sv
// pipeline stage 1 decides what occupies the tile under the beam
// game inputs are sampled every clock and must stay steady during active video
// player positions must be inside the 10x10 grid
// one register stage carries syncs and offsets along with the kind
`timescale 1ns/1ns
`default_nettype none

module tile_classifier
	import arena_video_pkg::*;
(
	input  wire              pixel_clk,
	input  wire              rst,
	input  wire beam_t       beam_i,
	input  wire grid_map_t   blocks_i,
	input  wire grid_map_t   bomb_lo_i,    // bomb level bit 0
	input  wire grid_map_t   bomb_hi_i,    // bomb level bit 1
	input  wire player_pos_t player1_i,
	input  wire player_pos_t player2_i,
	input  wire game_over_e  game_over_i,
	output paint_req_t       req_o
);

	logic [6:0] tile_idx;   // row*10 + col, 0..99
	logic [1:0] bomb_lvl;
	logic       p1_here;
	logic       p2_here;
	tile_kind_e kind;

	// row and col never leave the grid so the index stays below 100
	assign tile_idx = 7'(beam_i.row) * 7'(GRID_N) + 7'(beam_i.col);
	assign bomb_lvl = {bomb_hi_i[tile_idx], bomb_lo_i[tile_idx]};

	// a player who lost drops out and the arena below shows through
	assign p1_here = (player1_i.row == beam_i.row) && (player1_i.col == beam_i.col)
		&& (game_over_i != P2_WINS);
	assign p2_here = (player2_i.row == beam_i.row) && (player2_i.col == beam_i.col)
		&& (game_over_i != P1_WINS);

	//////////////////////////////////////////////////
	// occupant priority runs p1, p2, block, bomb, background

	always_comb begin
		if (p1_here) begin
			kind = TILE_PLAYER1;           // p1 also wins a shared tile
		end else if (p2_here) begin
			kind = TILE_PLAYER2;
		end else if (blocks_i[tile_idx]) begin
			kind = TILE_BLOCK;             // block hides any bomb level
		end else begin
			case (bomb_lvl)
				2'd1:    kind = TILE_BOMB1;
				2'd2:    kind = TILE_BOMB2;
				2'd3:    kind = TILE_BOMB3;
				default: kind = TILE_BACKGROUND;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// stage register

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			req_o.hsync_n <= 1'b1;             // syncs idle high
			req_o.vsync_n <= 1'b1;
			req_o.active  <= 1'b0;
			req_o.kind    <= TILE_BACKGROUND;
			req_o.off_x   <= '0;
			req_o.off_y   <= '0;
		end else begin
			req_o.hsync_n <= beam_i.hsync_n;
			req_o.vsync_n <= beam_i.vsync_n;
			req_o.active  <= beam_i.active;
			req_o.kind    <= kind;
			req_o.off_x   <= beam_i.off_x;     // mortar lines need these
			req_o.off_y   <= beam_i.off_y;
		end
	end

	// an out of range position would never be drawn
	a_players_on_grid : assert property (@(posedge pixel_clk) disable iff (rst)
		beam_i.active |-> (int'(player1_i.row) < GRID_N) && (int'(player1_i.col) < GRID_N)
			&& (int'(player2_i.row) < GRID_N) && (int'(player2_i.col) < GRID_N));

endmodule

`default_nettype wire

// File: verilog/pixel_painter.sv
// pipeline stage 2 maps tile kind to 3-3-2 colour and registers the syncs
// mortar lines assume 64x48 tiles
// pixels outside the picture are forced black
`timescale 1ns/1ns
`default_nettype none

module pixel_painter
	import arena_video_pkg::*;
(
	input  wire             pixel_clk,
	input  wire             rst,
	input  wire paint_req_t req_i,
	output rgb_t            rgb_o,
	output logic            hsync_o,
	output logic            vsync_o
);

	//////////////////////////////////////////////////
	// palette

	localparam rgb_t COL_BLACK      = '{red: 3'b000, green: 3'b000, blue: 2'b00};
	localparam rgb_t COL_BACKGROUND = '{red: 3'b111, green: 3'b111, blue: 2'b11};
	localparam rgb_t COL_BRICK      = '{red: 3'b110, green: 3'b010, blue: 2'b00};
	localparam rgb_t COL_BOMB1      = '{red: 3'b101, green: 3'b001, blue: 2'b11};
	localparam rgb_t COL_BOMB2      = '{red: 3'b100, green: 3'b000, blue: 2'b11};
	localparam rgb_t COL_BOMB3      = '{red: 3'b111, green: 3'b000, blue: 2'b00}; // about to blow
	localparam rgb_t COL_PLAYER1    = '{red: 3'b000, green: 3'b111, blue: 2'b00};
	localparam rgb_t COL_PLAYER2    = '{red: 3'b000, green: 3'b000, blue: 2'b11};

	logic mortar_x;
	logic mortar_y;
	rgb_t colour;

	// vertical joints every 13 px and horizontal courses at 0,9,19,29,39
	assign mortar_x = (req_i.off_x == 6'd0) || (req_i.off_x == 6'd13)
		|| (req_i.off_x == 6'd26) || (req_i.off_x == 6'd39) || (req_i.off_x == 6'd52);
	assign mortar_y = (req_i.off_y == 6'd0) || (req_i.off_y == 6'd9)
		|| (req_i.off_y == 6'd19) || (req_i.off_y == 6'd29) || (req_i.off_y == 6'd39);

	always_comb begin
		if (!req_i.active) begin
			colour = COL_BLACK;                // porches and blanking
		end else begin
			case (req_i.kind)
				TILE_BLOCK:   colour = (mortar_x || mortar_y) ? COL_BLACK : COL_BRICK;
				TILE_BOMB1:   colour = COL_BOMB1;
				TILE_BOMB2:   colour = COL_BOMB2;
				TILE_BOMB3:   colour = COL_BOMB3;
				TILE_PLAYER1: colour = COL_PLAYER1;
				TILE_PLAYER2: colour = COL_PLAYER2;
				default:      colour = COL_BACKGROUND;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output register keeps colour and syncs aligned

	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			rgb_o   <= COL_BLACK;
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else begin
			rgb_o   <= colour;
			hsync_o <= req_i.hsync_n;
			vsync_o <= req_i.vsync_n;
		end
	end

	// classifier must only ever hand over a defined occupant
	a_kind_legal : assert property (@(posedge pixel_clk) disable iff (rst)
		req_i.active |-> req_i.kind inside {TILE_BACKGROUND, TILE_BLOCK, TILE_BOMB1,
			TILE_BOMB2, TILE_BOMB3, TILE_PLAYER1, TILE_PLAYER2});

endmodule

`default_nettype wire

// File: verilog/arena_video_top.sv
// 640x480 arena renderer with a fixed latency of 2 pixel clocks
// outputs are black with syncs high during reset and for 2 clocks after
// game inputs must be held steady during active video
`timescale 1ns/1ns
`default_nettype none

module arena_video_top
	import arena_video_pkg::*;
#(
	parameter int H_BACK = 144, // first active column
	parameter int V_BACK = 31   // first active line
) (
	input  wire              pixel_clk,
	input  wire              rst,
	input  wire grid_map_t   blocks_i,
	input  wire grid_map_t   bomb_lo_i,
	input  wire grid_map_t   bomb_hi_i,
	input  wire player_pos_t player1_i,
	input  wire player_pos_t player2_i,
	input  wire game_over_e  game_over_i,
	output logic             hsync_o,
	output logic             vsync_o,
	output logic [2:0]       red_o,
	output logic [2:0]       green_o,
	output logic [1:0]       blue_o
);

	beam_t      beam;   // raster position in the same cycle
	paint_req_t req;    // classified 1 cycle later
	rgb_t       rgb;    // painted 2 cycles later

	raster_timing #(
		.H_BACK (H_BACK),
		.V_BACK (V_BACK)
	) u_raster (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.beam_o    (beam)
	);

	tile_classifier u_classify (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.beam_i      (beam),
		.blocks_i    (blocks_i),
		.bomb_lo_i   (bomb_lo_i),
		.bomb_hi_i   (bomb_hi_i),
		.player1_i   (player1_i),
		.player2_i   (player2_i),
		.game_over_i (game_over_i),
		.req_o       (req)
	);

	pixel_painter u_paint (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.req_i     (req),
		.rgb_o     (rgb),
		.hsync_o   (hsync_o),
		.vsync_o   (vsync_o)
	);

	// split for the dac pins
	assign red_o   = rgb.red;
	assign green_o = rgb.green;
	assign blue_o  = rgb.blue;

endmodule

`default_nettype wire

// File: testbench/arena_model.svh
// reference model of the arena renderer, included inside the testbench module
// needs arena_video_pkg imported and H_BACK / V_BACK declared before the include
// tile and offset come from division here while the DUT uses counters
`ifndef ARENA_MODEL_SVH
`define ARENA_MODEL_SVH

// what the DUT pins should show for one raster position
typedef struct packed {
	logic hsync_n;
	logic vsync_n;
	rgb_t rgb;
} video_out_t;

// reset and blanking value with syncs idle high and black rgb
localparam video_out_t OUT_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, rgb: 8'h00};

function automatic logic in_picture(int h, int v);
	return (h >= H_BACK) && (h < H_BACK + ACTIVE_W)
		&& (v >= V_BACK) && (v < V_BACK + ACTIVE_H);
endfunction

// occupant of one tile; the loser of a won game drops out of view
function automatic tile_kind_e expected_kind(int row, int col, grid_map_t blocks,
	grid_map_t bomb_lo, grid_map_t bomb_hi, player_pos_t p1, player_pos_t p2,
	game_over_e go);
	int idx;
	int level;
	idx   = row * GRID_N + col;              // flat map index
	level = 2 * int'(bomb_hi[idx]) + int'(bomb_lo[idx]);
	if (go != P2_WINS && int'(p1.row) == row && int'(p1.col) == col) begin
		return TILE_PLAYER1;                   // also taken when both share a tile
	end
	if (go != P1_WINS && int'(p2.row) == row && int'(p2.col) == col) begin
		return TILE_PLAYER2;
	end
	if (blocks[idx]) begin
		return TILE_BLOCK;
	end
	case (level)
		1:       return TILE_BOMB1;
		2:       return TILE_BOMB2;
		3:       return TILE_BOMB3;
		default: return TILE_BACKGROUND;
	endcase
endfunction

// palette with mortar joints on block tiles
function automatic rgb_t expected_colour(tile_kind_e kind, int off_x, int off_y);
	logic mortar;
	mortar = (off_x % 13 == 0) || (off_y inside {0, 9, 19, 29, 39}); // 0,13,26,39,52
	case (kind)
		TILE_BLOCK:   return mortar ? {3'b000, 3'b000, 2'b00} : {3'b110, 3'b010, 2'b00};
		TILE_BOMB1:   return {3'b101, 3'b001, 2'b11};
		TILE_BOMB2:   return {3'b100, 3'b000, 2'b11};
		TILE_BOMB3:   return {3'b111, 3'b000, 2'b00};
		TILE_PLAYER1: return {3'b000, 3'b111, 2'b00};
		TILE_PLAYER2: return {3'b000, 3'b000, 2'b11};
		default:      return {3'b111, 3'b111, 2'b11}; // background
	endcase
endfunction

// full pin state for raster position (h, v)
function automatic video_out_t expected_pixel(int h, int v, grid_map_t blocks,
	grid_map_t bomb_lo, grid_map_t bomb_hi, player_pos_t p1, player_pos_t p2,
	game_over_e go);
	video_out_t px;
	tile_kind_e kind;
	px.hsync_n = (h >= H_PULSE);             // pulse at the start of the line
	px.vsync_n = (v >= V_PULSE);
	px.rgb     = '0;                         // black outside the picture
	if (in_picture(h, v)) begin
		kind   = expected_kind((v - V_BACK) / TILE_H, (h - H_BACK) / TILE_W, blocks,
			bomb_lo, bomb_hi, p1, p2, go);
		px.rgb = expected_colour(kind, (h - H_BACK) % TILE_W, (v - V_BACK) % TILE_H);
	end
	return px;
endfunction

`endif

// File: testbench/tb_arena_video.sv
// self-checking testbench for arena_video_top over four frames of random game state
// game state is redrawn when the raster wraps to line 0 inside vertical blanking
// model output runs through a two entry delay line to match the 2 clock latency
`timescale 1ns/1ns
`default_nettype none

module tb_arena_video
	import arena_video_pkg::*;
();

	localparam int          H_BACK        = 144;
	localparam int          V_BACK        = 31;
	localparam int          RESET_CYCLES  = 5;
	localparam int          FRAMES        = 4;
	localparam int          SYNC_TIMEOUT  = 8;                      // cycles to first hsync
	localparam int          FRAME_TIMEOUT = H_TOTAL * V_TOTAL + 16;
	localparam logic [31:0] SEED          = 32'h96ea_a545;

	`include "arena_model.svh"

	logic        pixel_clk;
	logic        rst;
	grid_map_t   blocks;
	grid_map_t   bomb_lo;
	grid_map_t   bomb_hi;
	player_pos_t player1;
	player_pos_t player2;
	game_over_e  game_over;
	logic        hsync;
	logic        vsync;
	logic [2:0]  red;
	logic [2:0]  green;
	logic [1:0]  blue;

	int          h_pos;        // mirrors the DUT raster counters after each edge
	int          v_pos;
	int          frame_no;     // counts game state draws
	video_out_t  exp_q [2];    // [1] is due at the outputs now

	arena_video_top #(
		.H_BACK (H_BACK),
		.V_BACK (V_BACK)
	) uut (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.blocks_i    (blocks),
		.bomb_lo_i   (bomb_lo),
		.bomb_hi_i   (bomb_hi),
		.player1_i   (player1),
		.player2_i   (player2),
		.game_over_i (game_over),
		.hsync_o     (hsync),
		.vsync_o     (vsync),
		.red_o       (red),
		.green_o     (green),
		.blue_o      (blue)
	);

	always #5 pixel_clk = ~pixel_clk;  // 10 ns period

	//////////////////////////////////////////////////
	// helpers

	task automatic halt_run();
		$display("Errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// game_over walks through all four codes and players share a tile in the first frame
	task automatic draw_game_state();
		blocks    = grid_map_t'({$urandom, $urandom, $urandom, $urandom})
			& grid_map_t'({$urandom, $urandom, $urandom, $urandom}); // about 1 in 4
		bomb_lo   = grid_map_t'({$urandom, $urandom, $urandom, $urandom});
		bomb_hi   = grid_map_t'({$urandom, $urandom, $urandom, $urandom});
		player1   = '{row: cell_idx_t'($urandom % GRID_N), col: cell_idx_t'($urandom % GRID_N)};
		player2   = '{row: cell_idx_t'($urandom % GRID_N), col: cell_idx_t'($urandom % GRID_N)};
		if (frame_no == 0) begin
			player2 = player1;
		end
		game_over = game_over_e'(frame_no % 4);
		frame_no++;
	endtask

	task automatic check_outputs(video_out_t want);
		video_out_t got;
		got = {hsync, vsync, red, green, blue};
		assert ({got.hsync_n, got.vsync_n} == {want.hsync_n, want.vsync_n}) else begin
			$display("Fail at %0t ns: syncs expected h=%b v=%b, got h=%b v=%b", $time,
				want.hsync_n, want.vsync_n, got.hsync_n, got.vsync_n);
			halt_run();
		end
		assert (got.rgb == want.rgb) else begin
			$display("Fail at %0t ns: rgb expected %03b_%03b_%02b, got %03b_%03b_%02b", $time,
				want.rgb.red, want.rgb.green, want.rgb.blue,
				got.rgb.red, got.rgb.green, got.rgb.blue);
			halt_run();
		end
	endtask

	// one clock of raster tracking, pin checks and delay line feed
	task automatic step_cycle();
		@(posedge pixel_clk);
		#1;
		if (h_pos == H_TOTAL - 1) begin
			h_pos = 0;
			v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
		end else begin
			h_pos++;
		end
		if (h_pos == 0 && v_pos == 0) begin
			draw_game_state();                 // new frame starts inside blanking
		end
		check_outputs(exp_q[1]);
		exp_q[1] = exp_q[0];
		exp_q[0] = expected_pixel(h_pos, v_pos, blocks, bomb_lo, bomb_hi,
			player1, player2, game_over);
	endtask

	task automatic wait_first_hsync();
		int cycles;
		cycles = 0;
		while (hsync !== 1'b0) begin
			if (cycles >= SYNC_TIMEOUT) begin
				$display("timeout: no hsync pulse within %0d cycles of reset release",
					SYNC_TIMEOUT);
				halt_run();
			end
			step_cycle();
			cycles++;
		end
	endtask

	task automatic run_frame(int frame);
		int cycles;
		cycles = 0;
		do begin
			if (cycles >= FRAME_TIMEOUT) begin
				$display("timeout: raster did not wrap to line 0 during frame %0d", frame);
				halt_run();
			end
			step_cycle();
			cycles++;
		end while (!(h_pos == 0 && v_pos == 0));
	endtask

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		void'($urandom(SEED));
		pixel_clk = 1'b0;
		rst       = 1'b1;
		frame_no  = 0;
		h_pos     = 0;
		v_pos     = 0;
		draw_game_state();
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge pixel_clk);
			#1;
			check_outputs(OUT_IDLE);           // black with syncs high while reset is held
		end
		rst      = 1'b0;
		exp_q[1] = OUT_IDLE;                   // pipeline still holds reset values
		exp_q[0] = expected_pixel(0, 0, blocks, bomb_lo, bomb_hi,
			player1, player2, game_over);
		wait_first_hsync();
		for (int f = 0; f < FRAMES; f++) begin
			run_frame(f);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
verilog/arena_video_pkg.sv
verilog/raster_timing.sv
verilog/tile_classifier.sv
verilog/pixel_painter.sv
verilog/arena_video_top.sv
testbench/tb_arena_video.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -j 0
TOP        = tb_arena_video
FILELIST   = all.f
OBJ_DIR    = obj_dir
PASS_TEXT  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
